/* list.f */
hw/mem_unit_pkg.sv
hw/load_store_queue.sv
hw/fetch_queue.sv
hw/mem_access_engine.sv
hw/byte_ram.sv
hw/mem_unit_top.sv
verification/clock_gen.sv
verification/mem_unit_assert.sv
verification/mem_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --assert --top-module mem_unit_tb -f list.f
./obj_dir/Vmem_unit_tb | tee sim.log
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

/* verification/mem_unit_tb.sv */
module mem_unit_tb;
    import mem_unit_pkg::*;

    localparam int lsq_depth = 8;

    logic             clk;
    logic             rst;
    logic             dispatch_valid;
    lsq_entry_t       dispatch_entry;
    logic             lsq_full;
    logic             commit_valid;
    logic [tag_w-1:0] commit_tag;
    logic             fetch_valid;
    logic [31:0]      fetch_pc;
    logic             fq_full;
    logic             result_valid;
    mem_result_t      result;
    logic             ins_valid;
    ins_result_t      ins;
    mem_result_t      results [$];
    ins_result_t      fetched [$];
    logic [15:0]      lfsr = 16'd23804;

    clock_gen clock_gen_i (.clk, .rst);

    mem_unit_top #(.lsq_depth(lsq_depth), .fq_depth(8), .ram_bytes(256)) mem_unit_top_i (
        .clk, .rst, .dispatch_valid, .dispatch_entry, .lsq_full, .commit_valid, .commit_tag,
        .fetch_valid, .fetch_pc, .fq_full, .result_valid, .result, .ins_valid, .ins
    );

    // every completion pulse is kept, so none is lost while stimulus runs.
    always @(negedge clk) begin
        if (result_valid) begin
            results.push_back(result);
        end
        if (ins_valid) begin
            fetched.push_back(ins);
        end
    end

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16 + x^14 + x^13 + x^11.
            lfsr = {lfsr[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic report_failure();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_result(string name, mem_result_t expected, mem_result_t actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic compare_ins(string name, ins_result_t expected, ins_result_t actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic compare_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected %b, actual %b", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic await_output(string name, bit want_ins);
        int cycles;
        cycles = 0;
        while ((want_ins ? fetched.size() : results.size()) == 0) begin
            if (cycles == 200) begin
                $display("%s: no output from the DUT within 200 cycles", name);
                report_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic dispatch_op(mem_op_e op, logic [31:0] addr, logic [31:0] data,
                               logic [tag_w-1:0] tag, bit with_commit);
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch_entry <= lsq_entry_t'{op, addr, data, tag};
        @(posedge clk);
        dispatch_valid <= 1'b0;
        if (with_commit) begin
            commit_op(tag);
        end
    endtask

    task automatic commit_op(logic [tag_w-1:0] tag);
        @(posedge clk);
        commit_valid <= 1'b1;
        commit_tag   <= tag;
        @(posedge clk);
        commit_valid <= 1'b0;
    endtask

    task automatic request_fetch(logic [31:0] pc);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc    <= pc;
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic expect_result(string name, logic [tag_w-1:0] tag, logic [31:0] value);
        mem_result_t expected;
        mem_result_t got;
        expected.tag   = tag;
        expected.value = value;
        await_output(name, 1'b0);
        got = results.pop_front();
        compare_result(name, expected, got);
    endtask

    task automatic word_round_trip();
        logic [31:0] addr;
        logic [31:0] word;
        addr = 32'hc0 | (random_bits(4) << 2); // upper quarter, no other test writes there.
        word = random_bits(32);
        dispatch_op(op_sw, addr, word, 3'd1, 1'b1);
        dispatch_op(op_lw, addr, 32'd0, 3'd2, 1'b1);
        expect_result("word_round_trip", 3'd1, word);
        expect_result("word_round_trip", 3'd2, word);
    endtask

    task automatic load_extension();
        mem_op_e     ops [4];
        logic [31:0] expected [8];
        ops = '{op_lb, op_lbu, op_lh, op_lhu};
        // bytes 0x20 to 0x23 hold ff, f0, 81, 80.
        expected = '{32'hffffffff, 32'h000000ff, 32'hfffff0ff, 32'h0000f0ff,
                     32'hffffff81, 32'h00000081, 32'hffff8081, 32'h00008081};
        dispatch_op(op_sw, 32'h20, 32'h8081f0ff, 3'd0, 1'b1);
        expect_result("load_extension", 3'd0, 32'h8081f0ff);
        for (int i = 0; i < 8; i++) begin
            dispatch_op(ops[i % 4], 32'h20 + 32'(2 * (i / 4)), 32'd0, 3'(i), 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            expect_result("load_extension", 3'(i), expected[i]);
        end
    endtask

    task automatic partial_stores();
        logic [31:0] base;
        logic [31:0] byte_data;
        logic [31:0] half_data;
        logic [31:0] expected;
        base      = random_bits(32);
        byte_data = random_bits(32);
        half_data = random_bits(32);
        expected        = base;
        expected[15:8]  = byte_data[7:0];  // sb at offset 1.
        expected[31:16] = half_data[15:0]; // sh at offset 2.
        dispatch_op(op_sw, 32'h30, base, 3'd3, 1'b1);
        dispatch_op(op_sb, 32'h31, byte_data, 3'd4, 1'b1);
        dispatch_op(op_sh, 32'h32, half_data, 3'd5, 1'b1);
        dispatch_op(op_lw, 32'h30, 32'd0, 3'd6, 1'b1);
        expect_result("partial_stores", 3'd3, base);
        expect_result("partial_stores", 3'd4, byte_data);
        expect_result("partial_stores", 3'd5, half_data);
        expect_result("partial_stores", 3'd6, expected);
    endtask

    task automatic commit_gating();
        dispatch_op(op_lw, 32'h20, 32'd0, 3'd7, 1'b0);
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if (result_valid) begin
                $display("commit_gating: a result appeared before its commit");
                report_failure();
            end
        end
        commit_op(3'd7);
        expect_result("commit_gating", 3'd7, 32'h8081f0ff);
    endtask

    task automatic instruction_fetch();
        ins_result_t expected [2];
        ins_result_t got;
        for (int i = 0; i < 2; i++) begin
            expected[i].pc   = 32'h40 + 32'(4 * i);
            expected[i].word = random_bits(32);
            dispatch_op(op_sw, expected[i].pc, expected[i].word, 3'(i), 1'b1);
            expect_result("instruction_fetch", 3'(i), expected[i].word);
        end
        request_fetch(expected[0].pc);
        request_fetch(expected[1].pc);
        for (int i = 0; i < 2; i++) begin
            await_output("instruction_fetch", 1'b1);
            got = fetched.pop_front();
            compare_ins("instruction_fetch", expected[i], got);
        end
    endtask

    task automatic queue_full();
        logic [31:0] words [lsq_depth / 2];
        // first half stores, second half loads the same words back.
        for (int i = 0; i < lsq_depth; i++) begin
            if (i < lsq_depth / 2) begin
                words[i] = random_bits(32);
                dispatch_op(op_sw, 32'h80 + 32'(4 * i), words[i], 3'(i), 1'b0);
            end else begin
                dispatch_op(op_lw, 32'h80 + 32'(4 * (i - lsq_depth / 2)), 32'd0, 3'(i), 1'b0);
            end
        end
        @(negedge clk);
        compare_flag("queue_full", 1'b1, lsq_full);
        for (int i = 0; i < lsq_depth; i++) begin
            commit_op(3'(i));
        end
        for (int i = 0; i < lsq_depth; i++) begin
            expect_result("queue_full", 3'(i), words[i % (lsq_depth / 2)]);
        end
        @(negedge clk);
        compare_flag("queue_full", 1'b0, lsq_full);
    endtask

    initial begin
        dispatch_valid = 1'b0;
        dispatch_entry = '0;
        commit_valid   = 1'b0;
        commit_tag     = '0;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        repeat (5) @(negedge clk);
        compare_flag("reset", 1'b0, lsq_full);
        compare_flag("reset", 1'b0, fq_full);
        word_round_trip();
        load_extension();
        partial_stores();
        commit_gating();
        instruction_fetch();
        queue_full();
        $display("All tests passed");
        $finish;
    end
endmodule

/* verification/mem_unit_assert.sv */
module mem_unit_assert (
    input logic        clk,
    input logic        rst,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic [31:0] wb_adr,
    input logic        dispatch_valid,
    input logic        lsq_full,
    input logic        fetch_valid,
    input logic        fq_full
);
    stb_inside_cyc: assert property (@(posedge clk) disable iff (!rst) wb_stb |-> wb_cyc)
        else $error("wb_stb is high while wb_cyc is low");

    adr_held: assert property (@(posedge clk) disable iff (!rst)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr changed while the strobe waited for ack");

    // the master releases the strobe right after ack, so each ack stays one cycle.
    stb_drop_after_ack: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |=> !wb_stb)
        else $error("wb_stb stayed high in the cycle after wb_ack");

    no_dispatch_full: assert property (@(posedge clk) disable iff (!rst)
        lsq_full |-> !dispatch_valid)
        else $error("dispatch while the load/store queue is full");

    no_fetch_full: assert property (@(posedge clk) disable iff (!rst) fq_full |-> !fetch_valid)
        else $error("fetch while the fetch queue is full");
endmodule

bind mem_unit_top mem_unit_assert mem_unit_assert_i (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_ack, .wb_adr,
    .dispatch_valid, .lsq_full, .fetch_valid, .fq_full
);

/* verification/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b0; // low for three rising edges.
        repeat (3) @(posedge clk);
        rst <= 1'b1;
    end
endmodule

/* hw/mem_unit_top.sv */
module mem_unit_top #(
    parameter int lsq_depth = 8,
    parameter int fq_depth  = 8,
    parameter int ram_bytes = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           dispatch_valid,
    input  mem_unit_pkg::lsq_entry_t       dispatch_entry,
    output logic                           lsq_full,
    input  logic                           commit_valid,
    input  logic [mem_unit_pkg::tag_w-1:0] commit_tag,
    input  logic                           fetch_valid,
    input  logic [31:0]                    fetch_pc,
    output logic                           fq_full,
    output logic                           result_valid,
    output mem_unit_pkg::mem_result_t      result,
    output logic                           ins_valid,
    output mem_unit_pkg::ins_result_t      ins
);
    import mem_unit_pkg::*;

    lsq_entry_t  lsq_head;
    logic        lsq_head_ready;
    logic        lsq_pop;
    logic [31:0] fq_head_pc;
    logic        fq_head_valid;
    logic        fq_pop;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;

    load_store_queue #(.lsq_depth(lsq_depth)) load_store_queue_i (
        .clk, .rst,
        .dispatch_valid, .dispatch_entry,
        .commit_valid, .commit_tag,
        .lsq_pop, .lsq_head, .lsq_head_ready, .lsq_full
    );

    fetch_queue #(.fq_depth(fq_depth)) fetch_queue_i (
        .clk, .rst,
        .fetch_valid, .fetch_pc,
        .fq_pop, .fq_head_pc, .fq_head_valid, .fq_full
    );

    mem_access_engine mem_access_engine_i (
        .clk, .rst,
        .lsq_head, .lsq_head_ready, .fq_head_pc, .fq_head_valid,
        .lsq_pop, .fq_pop,
        .result_valid, .result, .ins_valid, .ins,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    byte_ram #(.ram_bytes(ram_bytes)) byte_ram_i (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

endmodule

/* hw/byte_ram.sv */
module byte_ram #(
    parameter int ram_bytes = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [7:0]  wb_dat_w,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack
);
    localparam int adr_w = $clog2(ram_bytes);

    logic [7:0]       mem [ram_bytes];
    logic [adr_w-1:0] index;
    logic             accept;

    assign index  = wb_adr[adr_w-1:0]; // address wraps at ram_bytes.
    assign accept = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept; // one cycle per strobe.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (wb_we) begin
                mem[index] <= wb_dat_w;
            end
            wb_dat_r <= mem[index];
        end
    end

endmodule

/* hw/mem_access_engine.sv */
module mem_access_engine (
    input  logic                      clk,
    input  logic                      rst,
    input  mem_unit_pkg::lsq_entry_t  lsq_head,
    input  logic                      lsq_head_ready,
    input  logic [31:0]               fq_head_pc,
    input  logic                      fq_head_valid,
    output logic                      lsq_pop,
    output logic                      fq_pop,
    output logic                      result_valid,
    output mem_unit_pkg::mem_result_t result,
    output logic                      ins_valid,
    output mem_unit_pkg::ins_result_t ins,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [31:0]               wb_adr,
    output logic [7:0]                wb_dat_w,
    input  logic [7:0]                wb_dat_r,
    input  logic                      wb_ack
);
    import mem_unit_pkg::*;

    typedef enum logic [1:0] {st_idle, st_bus, st_gap} state_e;

    state_e           state;
    logic             job_fetch;
    mem_op_e          job_op;
    logic [31:0]      job_addr;
    logic [31:0]      job_data;
    logic [tag_w-1:0] job_tag;
    logic [1:0]       idx;
    logic [1:0]       last_idx;
    logic [31:0]      asm;
    logic [31:0]      gathered;
    logic [31:0]      load_value;

    function automatic logic [1:0] last_index(mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: last_index = 2'd0;
            op_lh, op_lhu, op_sh: last_index = 2'd1;
            default:              last_index = 2'd3;
        endcase
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    // earlier bytes plus the one arriving with this ack.
    always_comb begin
        gathered = asm;
        gathered[{idx, 3'b000} +: 8] = wb_dat_r;
        case (job_op)
            op_lb:   load_value = {{24{gathered[7]}}, gathered[7:0]};
            op_lh:   load_value = {{16{gathered[15]}}, gathered[15:0]};
            op_lbu:  load_value = {24'd0, gathered[7:0]};
            op_lhu:  load_value = {16'd0, gathered[15:0]};
            op_sb, op_sh, op_sw: load_value = job_data;
            default: load_value = gathered;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= st_idle;
            wb_cyc       <= 1'b0;
            wb_stb       <= 1'b0;
            wb_we        <= 1'b0;
            result_valid <= 1'b0;
            ins_valid    <= 1'b0;
            lsq_pop      <= 1'b0;
            fq_pop       <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            ins_valid    <= 1'b0;
            lsq_pop      <= 1'b0;
            fq_pop       <= 1'b0;
            case (state)
                st_idle: begin
                    idx <= 2'd0;
                    if (lsq_head_ready) begin // memory op beats fetch.
                        job_fetch <= 1'b0;
                        job_op    <= lsq_head.op;
                        job_addr  <= lsq_head.addr;
                        job_data  <= lsq_head.data;
                        job_tag   <= lsq_head.tag;
                        last_idx  <= last_index(lsq_head.op);
                        wb_cyc    <= 1'b1;
                        wb_stb    <= 1'b1;
                        wb_we     <= is_store(lsq_head.op);
                        wb_adr    <= lsq_head.addr;
                        wb_dat_w  <= lsq_head.data[7:0];
                        state     <= st_bus;
                    end else if (fq_head_valid) begin
                        job_fetch <= 1'b1;
                        job_addr  <= fq_head_pc;
                        last_idx  <= 2'd3;
                        wb_cyc    <= 1'b1;
                        wb_stb    <= 1'b1;
                        wb_we     <= 1'b0;
                        wb_adr    <= fq_head_pc;
                        state     <= st_bus;
                    end
                end
                st_bus: begin
                    if (wb_ack) begin
                        asm    <= gathered;
                        wb_stb <= 1'b0;
                        idx    <= idx + 2'd1;
                        state  <= st_gap;
                        if (idx == last_idx) begin
                            wb_cyc <= 1'b0;
                            wb_we  <= 1'b0;
                            if (job_fetch) begin
                                ins_valid <= 1'b1;
                                fq_pop    <= 1'b1;
                                ins.pc    <= job_addr;
                                ins.word  <= gathered;
                            end else begin
                                result_valid <= 1'b1;
                                lsq_pop      <= 1'b1;
                                result.tag   <= job_tag;
                                result.value <= load_value;
                            end
                        end
                    end
                end
                st_gap: begin
                    // pop lands here, so idle sees the next head.
                    if (wb_cyc) begin
                        wb_stb   <= 1'b1;
                        wb_adr   <= job_addr + {30'd0, idx};
                        wb_dat_w <= job_data[{idx, 3'b000} +: 8];
                        state    <= st_bus;
                    end else begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* hw/fetch_queue.sv */
module fetch_queue #(
    parameter int fq_depth = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_pc,
    input  logic        fq_pop,
    output logic [31:0] fq_head_pc,
    output logic        fq_head_valid,
    output logic        fq_full
);
    localparam int ptr_w = $clog2(fq_depth);
    localparam int cnt_w = $clog2(fq_depth + 1);

    logic [31:0]      pcs [fq_depth];
    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic             push;

    assign push = fetch_valid && !fq_full;

    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (fq_pop) begin
                head <= head + 1'b1;
            end
            case ({push, fq_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pcs[tail] <= fetch_pc;
        end
    end

    assign fq_head_pc    = pcs[head];
    assign fq_head_valid = (count != '0);
    assign fq_full       = (count == cnt_w'(fq_depth));

endmodule

/* hw/load_store_queue.sv */
module load_store_queue #(
    parameter int lsq_depth = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           dispatch_valid,
    input  mem_unit_pkg::lsq_entry_t       dispatch_entry,
    input  logic                           commit_valid,
    input  logic [mem_unit_pkg::tag_w-1:0] commit_tag,
    input  logic                           lsq_pop,
    output mem_unit_pkg::lsq_entry_t       lsq_head,
    output logic                           lsq_head_ready,
    output logic                           lsq_full
);
    import mem_unit_pkg::*;

    localparam int ptr_w = $clog2(lsq_depth);
    localparam int cnt_w = $clog2(lsq_depth + 1);

    lsq_entry_t           entries [lsq_depth];
    logic [lsq_depth-1:0] committed;
    logic [lsq_depth-1:0] occupied;
    logic [ptr_w-1:0]     head;
    logic [ptr_w-1:0]     tail;
    logic [cnt_w-1:0]     count;
    logic                 push;

    assign push = dispatch_valid && !lsq_full;

    // a slot is live when its distance from head is below the count.
    always_comb begin
        logic [ptr_w-1:0] offset;
        for (int i = 0; i < lsq_depth; i++) begin
            offset = ptr_w'(i) - head;
            occupied[i] = {1'b0, offset} < count;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            committed <= '0;
        end else begin
            for (int i = 0; i < lsq_depth; i++) begin
                if (commit_valid && occupied[i] && entries[i].tag == commit_tag) begin
                    committed[i] <= 1'b1;
                end
            end
            if (push) begin
                committed[tail] <= 1'b0; // new entry waits for its commit.
                tail            <= tail + 1'b1;
            end
            if (lsq_pop) begin
                head <= head + 1'b1;
            end
            case ({push, lsq_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= dispatch_entry;
        end
    end

    assign lsq_head       = entries[head];
    assign lsq_head_ready = (count != '0) && committed[head];
    assign lsq_full       = (count == cnt_w'(lsq_depth));

endmodule

/* hw/mem_unit_pkg.sv */
package mem_unit_pkg;

    // width of a reorder-buffer tag.
    parameter int tag_w = 3;

    // memory operations only; loads first, then stores.
    typedef enum logic [3:0] {
        op_lb  = 4'd0,
        op_lh  = 4'd1,
        op_lw  = 4'd2,
        op_lbu = 4'd3,
        op_lhu = 4'd4,
        op_sb  = 4'd5,
        op_sh  = 4'd6,
        op_sw  = 4'd7
    } mem_op_e;

    // one queued memory operation, 71 bits.
    typedef struct packed {
        mem_op_e          op;
        logic [31:0]      addr;
        logic [31:0]      data; // store value.
        logic [tag_w-1:0] tag;
    } lsq_entry_t;

    // completion of a load or a store, 35 bits.
    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [31:0]      value; // store data for stores.
    } mem_result_t;

    // one fetched instruction word and its pc.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
    } ins_result_t;

endpackage
